// File: Bender.yml
package:
  name: decodeExpander

export_include_dirs:
  - .

sources:
  - armInstrPkg.sv
  - microOpPkg.sv
  - condCheck.sv
  - microOpConfig.sv
  - microOpFsm.sv
  - decodeExpander.sv
  - target: test
    files:
      - microOpTb.sv

// File: armInstrPkg.sv
// ARM instruction formats
package armInstrPkg;

	// Condition field encodings
	typedef enum logic [3:0] {
		EQ, NE, // Zero set / clear
		CS, CC, // Carry set / clear
		MI, PL, // Negative / positive
		VS, VC, // Overflow set / clear
		HI, LS, // Unsigned higher / lower or same
		GE, LT, // Signed compare
		GT, LE,
		AL,     // Always
		NV      // Never, reserved encoding
	} cond_t;

	// Status flags from the ALU
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	// One instruction word, seen as data processing or as multiply
	typedef union packed {
		struct packed {
			cond_t      cond;      // [31:28]
			logic [1:0] opClass;   // [27:26] 00 for data processing
			logic       imm;       // [25] Immediate operand 2
			logic [3:0] opcode;    // [24:21]
			logic       setFlags;  // [20] S bit
			logic [3:0] rn;        // [19:16] First operand
			logic [3:0] rd;        // [15:12] Destination
			logic [4:0] shiftAmt;  // [11:7] Amount, or Rs in [11:8]
			logic [1:0] shiftType; // [6:5] LSL LSR ASR ROR
			logic       regShift;  // [4] Shift by register
			logic [3:0] rm;        // [3:0] Second operand
		} dataProc;
		struct packed {
			cond_t      cond;       // [31:28]
			logic [3:0] mulClass;   // [27:24] Zero for multiplies
			logic       longMul;    // [23] 64-bit result
			logic       signedMul;  // [22] Signed operands
			logic       accumulate; // [21] A bit
			logic       setFlags;   // [20] S bit
			logic [3:0] rdHi;       // [19:16] RdHi, or Rd for short form
			logic [3:0] rdLo;       // [15:12] RdLo, or Rn accumulator
			logic [3:0] rs;         // [11:8]
			logic [3:0] marker;     // [7:4] Always 1001
			logic [3:0] rm;         // [3:0]
		} multiply;
	} armInstr_t;

	localparam logic [3:0] OP_ADD = 4'b0100; // Data-processing opcodes
	localparam logic [3:0] OP_MOV = 4'b1101;

endpackage

// File: condCheck.sv
// ARM condition unit
`timescale 1ns/1ps

module condCheck
	import armInstrPkg::*;
(
	input  flags_t flags,
	input  cond_t  cond,
	output logic   condPass
);

	always_comb begin
		case (cond)
			EQ:      condPass = flags.z;
			NE:      condPass = !flags.z;
			CS:      condPass = flags.c;
			CC:      condPass = !flags.c;
			MI:      condPass = flags.n;
			PL:      condPass = !flags.n;
			VS:      condPass = flags.v;
			VC:      condPass = !flags.v;
			HI:      condPass = flags.c && !flags.z;           // Unsigned >
			LS:      condPass = !flags.c || flags.z;           // Unsigned <=
			GE:      condPass = (flags.n == flags.v);          // Signed >=
			LT:      condPass = (flags.n != flags.v);          // Signed <
			GT:      condPass = !flags.z && (flags.n == flags.v);
			LE:      condPass = flags.z || (flags.n != flags.v);
			AL:      condPass = 1'b1;
			default: condPass = 1'b0;                          // NV never executes
		endcase
	end

endmodule

// File: decodeExpander.sv
// Decode-stage micro-op expander
`timescale 1ns/1ps
`include "microOp_params.svh"

module decodeExpander
	import armInstrPkg::*;
	import microOpPkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  armInstr_t               defaultInstrD,
	input  logic                    stallUop,
	input  flags_t                  flags,
	input  logic                    cfgWrite,
	input  logic [1:0]              cfgData,        // {MAC, RSR}
	output logic                    instrMuxD,
	output logic                    doNotUpdateFlagD,
	output logic                    uOpStallD,      // Toward fetch
	output logic                    prevRsrState,
	output logic                    keepV,
	output rzRoute_t                regFileRz,
	output armInstr_t               uOpInstrD,
	output logic [`COUNT_WIDTH-1:0] expansionCount
);

	logic condPass;
	logic enableRsr;
	logic enableMac;
	logic expandStart;

	condCheck u_condCheck (
		.flags    (flags),
		.cond     (defaultInstrD.dataProc.cond), // Same bits in both views
		.condPass (condPass)
	);

	microOpConfig u_config (
		.clk            (clk),
		.reset          (reset),
		.cfgWrite       (cfgWrite),
		.cfgData        (cfgData),
		.expandStart    (expandStart),
		.enableRsr      (enableRsr),
		.enableMac      (enableMac),
		.expansionCount (expansionCount)
	);

	microOpFsm u_fsm (
		.clk              (clk),
		.reset            (reset),
		.defaultInstrD    (defaultInstrD),
		.stallUop         (stallUop),
		.condPass         (condPass),
		.enableRsr        (enableRsr),
		.enableMac        (enableMac),
		.instrMuxD        (instrMuxD),
		.doNotUpdateFlagD (doNotUpdateFlagD),
		.uOpStallD        (uOpStallD),
		.prevRsrState     (prevRsrState),
		.keepV            (keepV),
		.expandStart      (expandStart),
		.regFileRz        (regFileRz),
		.uOpInstrD        (uOpInstrD)
	);

endmodule

// File: microOpConfig.sv
// Expansion enables and counter
`timescale 1ns/1ps
`include "microOp_params.svh"

module microOpConfig (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cfgWrite,       // Load strobe for the enables
	input  logic [1:0]              cfgData,        // {MAC, RSR}
	input  logic                    expandStart,    // One pulse per expansion
	output logic                    enableRsr,
	output logic                    enableMac,
	output logic [`COUNT_WIDTH-1:0] expansionCount
);

	logic [1:0] enables; // {MAC, RSR}

	always_ff @(posedge clk) begin
		if (reset) begin
			enables <= `CFG_RESET; // Both classes on
		end else if (cfgWrite) begin
			enables <= cfgData;
		end
	end

	assign enableRsr = enables[0];
	assign enableMac = enables[1];

	// Started expansions, wraps at the top of the range
	always_ff @(posedge clk) begin
		if (reset) begin
			expansionCount <= '0;
		end else if (expandStart) begin
			expansionCount <= expansionCount + 1'b1;
		end
	end

	// FSM must not start while every class is switched off
	assert property (@(posedge clk) disable iff (reset)
		expandStart |-> (enableRsr || enableMac))
		else $error("microOpConfig: expansion started with both classes disabled");

endmodule

// File: microOpFsm.sv
// Micro-op expansion FSM
`timescale 1ns/1ps
`include "microOp_params.svh"

module microOpFsm
	import armInstrPkg::*;
	import microOpPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  armInstr_t defaultInstrD,    // Held by fetch while stalled
	input  logic      stallUop,         // Hazard stall, freezes the state
	input  logic      condPass,
	input  logic      enableRsr,
	input  logic      enableMac,
	output logic      instrMuxD,        // Select uOpInstrD over the raw word
	output logic      doNotUpdateFlagD,
	output logic      uOpStallD,        // Hold fetch for the second micro-op
	output logic      prevRsrState,     // Second micro-op in flight
	output logic      keepV,            // MUL keeps the V flag
	output logic      expandStart,
	output rzRoute_t  regFileRz,
	output armInstr_t uOpInstrD
);

	uopState_t state;
	uopState_t nextState;

	logic [`INSTR_WIDTH-1:0] instrBits; // Flat word, bit 7 straddles shiftAmt
	logic                    isRsr;
	logic                    isMac;
	logic                    rsrGo;
	logic                    macGo;

	assign instrBits = defaultInstrD;

	// Class detection
	assign isMac = defaultInstrD.multiply.accumulate &&
		(defaultInstrD.multiply.marker == 4'b1001);            // MLA, UMLAL, SMLAL
	assign isRsr = (defaultInstrD.dataProc.opClass == 2'b00) &&
		!defaultInstrD.dataProc.imm &&
		!instrBits[7] &&
		defaultInstrD.dataProc.regShift;                       // Shift by Rs

	// Expand only when the instruction executes and its class is on
	assign macGo = isMac && enableMac && condPass;
	assign rsrGo = isRsr && enableRsr && condPass;

	// Pulse on the edge that leaves READY
	assign expandStart = (state == READY) && (macGo || rsrGo) && !stallUop;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= READY;
		end else if (!stallUop) begin
			state <= nextState; // Frozen under back-pressure
		end
	end

	// Mealy outputs from state and the held instruction
	always_comb begin
		nextState        = READY;
		instrMuxD        = 1'b0;
		doNotUpdateFlagD = 1'b0;
		uOpStallD        = 1'b0;
		prevRsrState     = 1'b0;
		keepV            = 1'b0;
		regFileRz        = ROUTE_NONE;
		uOpInstrD        = defaultInstrD; // Pass-through unless rewritten

		case (state)
			READY: begin
				if (macGo) begin
					// MUL Rz, Rm, Rs
					nextState                     = MULTIPLY;
					instrMuxD                     = 1'b1;
					uOpStallD                     = 1'b1;
					keepV                         = 1'b1;
					regFileRz                     = ROUTE_FIRST;
					uOpInstrD.multiply.longMul    = 1'b0;    // 32-bit product only
					uOpInstrD.multiply.accumulate = 1'b0;    // Plain MUL, sign kept
					uOpInstrD.multiply.setFlags   = 1'b0;
					uOpInstrD.multiply.rdHi       = RZ_REG;  // Product to Rz
					uOpInstrD.multiply.rdLo       = 4'b0000; // SBZ
				end else if (rsrGo) begin
					// MOV Rz, Rm <shift> Rs
					nextState                   = RSR;
					instrMuxD                   = 1'b1;
					doNotUpdateFlagD            = 1'b1;
					uOpStallD                   = 1'b1;
					regFileRz                   = ROUTE_FIRST;
					uOpInstrD.dataProc.opcode   = OP_MOV;
					uOpInstrD.dataProc.setFlags = 1'b0;
					uOpInstrD.dataProc.rn       = 4'b0000; // SBZ for MOV
					uOpInstrD.dataProc.rd       = RZ_REG;
				end
			end

			RSR: begin
				// Original op with Rz as unshifted Rm
				instrMuxD                    = 1'b1;
				prevRsrState                 = 1'b1;
				regFileRz                    = ROUTE_RM;
				uOpInstrD.dataProc.shiftAmt  = 5'b00000; // LSL #0
				uOpInstrD.dataProc.shiftType = 2'b00;
				uOpInstrD.dataProc.regShift  = 1'b0;
				uOpInstrD.dataProc.rm        = RZ_REG;
			end

			MULTIPLY: begin
				instrMuxD        = 1'b1;
				doNotUpdateFlagD = 1'b1;
				prevRsrState     = 1'b1;
				if (defaultInstrD.multiply.longMul) begin
					// RdHi:RdLo accumulate, old halves read through Rs and Rm
					regFileRz             = ROUTE_NONE;
					uOpInstrD.multiply.rs = defaultInstrD.multiply.rdLo;
					uOpInstrD.multiply.rm = defaultInstrD.multiply.rdHi;
				end else begin
					// ADD Rd, Rz, Rn
					regFileRz                   = ROUTE_RN;
					uOpInstrD                   = '0;                            // LSL #0 reg
					uOpInstrD.dataProc.cond     = defaultInstrD.multiply.cond;
					uOpInstrD.dataProc.opcode   = OP_ADD;
					uOpInstrD.dataProc.setFlags = defaultInstrD.multiply.setFlags;
					uOpInstrD.dataProc.rn       = RZ_REG;                        // Product
					uOpInstrD.dataProc.rd       = defaultInstrD.multiply.rdHi;   // MLA Rd
					uOpInstrD.dataProc.rm       = defaultInstrD.multiply.rdLo;   // Accumulator
				end
			end

			default: begin
				nextState = READY; // Recover from a corrupt state
			end
		endcase
	end

	// A stall toward fetch is always followed by the second micro-op
	assert property (@(posedge clk) disable iff (reset)
		(uOpStallD && !stallUop) |=> (state != READY) && !uOpStallD)
		else $error("microOpFsm: first micro-op not followed by second");

	assert property (@(posedge clk) disable iff (reset)
		state inside {READY, RSR, MULTIPLY})
		else $error("microOpFsm: illegal state %0d", state);

endmodule

// File: microOpPkg.sv
// Micro-op sequencer types
package microOpPkg;

	// Sequencer states, one per second micro-op
	typedef enum logic [1:0] {
		READY,   // Pass-through or first micro-op
		RSR,     // Rewritten shifted-register op
		MULTIPLY // Accumulate step of a MAC
	} uopState_t;

	// Register-file Rz steering
	// Bit 3 picks Rz as RA1, bits 2..0 put Rz on WA3, RA2, RA1
	typedef logic [3:0] rzRoute_t;

	localparam rzRoute_t ROUTE_NONE  = 4'b0000; // Architectural registers only
	localparam rzRoute_t ROUTE_FIRST = 4'b1100; // First micro-op writes Rz
	localparam rzRoute_t ROUTE_RM    = 4'b0010; // Rz read as Rm
	localparam rzRoute_t ROUTE_RN    = 4'b0001; // Rz read as Rn

	// Hidden register number as seen in the instruction fields
	localparam logic [3:0] RZ_REG = 4'b1111;

endpackage

// File: microOpModel.svh
// Micro-op expander reference model
`ifndef MICROOP_MODEL_SVH
`define MICROOP_MODEL_SVH

localparam logic [1:0] S_READY = 2'd0; // Model states
localparam logic [1:0] S_RSR   = 2'd1;
localparam logic [1:0] S_MUL   = 2'd2;

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsrStep(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// ARM condition field against {N, Z, C, V}
function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] nzcv);
	logic n, z, c, v;
	n = nzcv[3];
	z = nzcv[2];
	c = nzcv[1];
	v = nzcv[0];
	case (cond)
		4'h0: return z;
		4'h1: return !z;
		4'h2: return c;
		4'h3: return !c;
		4'h4: return n;
		4'h5: return !n;
		4'h6: return v;
		4'h7: return !v;
		4'h8: return c && !z;
		4'h9: return !c || z;
		4'hA: return n == v;
		4'hB: return n != v;
		4'hC: return !z && (n == v);
		4'hD: return z || (n != v);
		4'hE: return 1'b1;  // AL
		default: return 1'b0; // NV
	endcase
endfunction

function automatic logic isMacWord(input logic [31:0] w);
	return w[21] && (w[7:4] == 4'b1001); // A bit and multiply marker
endfunction

function automatic logic isRsrWord(input logic [31:0] w);
	return (w[27:25] == 3'b000) && !w[7] && w[4]; // Register operand shifted by Rs
endfunction

// Expected outputs for one cycle, ctl is {instrMux, noFlags, stall, prevRsr, keepV}
task automatic predictOutputs(
	input  logic [1:0]  st,
	input  logic [31:0] w,
	input  logic        condOk,
	input  logic [1:0]  en,     // {MAC, RSR}
	output logic [31:0] uop,
	output logic [3:0]  route,
	output logic [4:0]  ctl,
	output logic [1:0]  nextSt
);
	uop    = w;
	route  = 4'b0000;
	ctl    = 5'b00000;
	nextSt = S_READY;
	case (st)
		S_READY: begin
			if (isMacWord(w) && en[1] && condOk) begin
				uop    = {w[31:24], 1'b0, w[22], 2'b00, 4'hF, 4'h0, w[11:0]}; // MUL Rz
				route  = 4'b1100;
				ctl    = 5'b10101;
				nextSt = S_MUL;
			end else if (isRsrWord(w) && en[0] && condOk) begin
				uop    = {w[31:25], 4'b1101, 1'b0, 4'h0, 4'hF, w[11:0]}; // MOV Rz, shifted
				route  = 4'b1100;
				ctl    = 5'b11100;
				nextSt = S_RSR;
			end
		end
		S_RSR: begin
			uop   = {w[31:12], 8'h00, 4'hF}; // Rm replaced by Rz, no shift
			route = 4'b0010;
			ctl   = 5'b10010;
		end
		default: begin
			ctl = 5'b11010;
			if (w[23]) begin
				uop   = {w[31:12], w[15:12], w[7:4], w[19:16]}; // Old RdLo, RdHi as operands
				route = 4'b0000;
			end else begin
				uop   = {w[31:28], 3'b000, 4'b0100, w[20], 4'hF, w[19:16], 8'h00, w[15:12]};
				route = 4'b0001; // ADD Rd, Rz, Rn
			end
		end
	endcase
endtask

`endif

// File: microOpTb.sv
// Micro-op expander testbench
`timescale 1ns/1ps
`include "microOp_params.svh"

module microOpTb;

	localparam int RESET_CYCLES = 8;
	localparam int N_PASS  = 200;
	localparam int N_RSR   = 300;
	localparam int N_MAC   = 300;
	localparam int N_COND  = 400;
	localparam int N_STALL = 400;
	localparam int CYCLE_LIMIT = RESET_CYCLES + N_PASS + N_RSR + N_MAC + N_COND + N_STALL + 50;

	localparam int M_PASS = 0; // Stimulus modes
	localparam int M_RSR = 1;
	localparam int M_MAC = 2;
	localparam int M_COND = 3;
	localparam int M_STALL = 4;

	localparam int K_PLAIN = 0; // Instruction kinds
	localparam int K_RSR = 1;
	localparam int K_SHORT = 2;
	localparam int K_LONG = 3;

	logic                    clk = 1'b0;
	logic                    reset;
	logic [31:0]             defaultInstrD;
	logic                    stallUop;
	logic [3:0]              flags;     // {N, Z, C, V}
	logic                    cfgWrite;
	logic [1:0]              cfgData;
	logic                    instrMuxD;
	logic                    doNotUpdateFlagD;
	logic                    uOpStallD;
	logic                    prevRsrState;
	logic                    keepV;
	logic [3:0]              regFileRz;
	logic [31:0]             uOpInstrD;
	logic [`COUNT_WIDTH-1:0] expansionCount;

	logic [15:0]             lfsrState;
	logic [1:0]              mState;      // Model state, one edge ahead after update
	logic [`COUNT_WIDTH-1:0] mCount;
	logic [1:0]              mEnables;    // {MAC, RSR}
	logic                    expUopStall; // Predicted stall toward fetch
	logic [31:0]             expUop;
	logic [3:0]              expRoute;
	logic [4:0]              expCtl;
	logic [1:0]              nextSt;
	int                      errorCount = 0;
	int                      checkCount = 0;
	int                      cycleCount = 0;

	`include "microOpModel.svh"

	always #20 clk = ~clk; // 40 ns period

	decodeExpander u_dut (
		.clk              (clk),
		.reset            (reset),
		.defaultInstrD    (defaultInstrD),
		.stallUop         (stallUop),
		.flags            (flags),
		.cfgWrite         (cfgWrite),
		.cfgData          (cfgData),
		.instrMuxD        (instrMuxD),
		.doNotUpdateFlagD (doNotUpdateFlagD),
		.uOpStallD        (uOpStallD),
		.prevRsrState     (prevRsrState),
		.keepV            (keepV),
		.regFileRz        (regFileRz),
		.uOpInstrD        (uOpInstrD),
		.expansionCount   (expansionCount)
	);

	// Takes n LFSR output bits, one step each
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] makeInstr(input int kind, input logic [3:0] cond);
		logic [31:0] w;
		w = randBits(32);
		case (kind)
			K_RSR:   w = {cond, 3'b000, w[24:8], 1'b0, w[6:5], 1'b1, w[3:0]};
			K_SHORT: w = {cond, 4'b0000, 2'b00, 1'b1, w[20:8], 4'b1001, w[3:0]}; // MLA
			K_LONG:  w = {cond, 4'b0000, 1'b1, w[22], 1'b1, w[20:8], 4'b1001, w[3:0]};
			default: w = {cond, 2'b00, 1'b1, w[24:22], 1'b0, w[20:0]}; // Immediate DP
		endcase
		return w;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	// Outputs settle between edges, model steps after the compare
	always @(negedge clk) begin
		if (reset) begin
			mState      = S_READY;
			mCount      = '0;
			mEnables    = `CFG_RESET;
			expUopStall = 1'b0;
		end else begin
			predictOutputs(mState, defaultInstrD, condHolds(defaultInstrD[31:28], flags),
				mEnables, expUop, expRoute, expCtl, nextSt);
			checkValue("uOpInstrD", uOpInstrD, expUop);
			checkValue("regFileRz", regFileRz, expRoute);
			checkValue("instrMuxD", instrMuxD, expCtl[4]);
			checkValue("doNotUpdateFlagD", doNotUpdateFlagD, expCtl[3]);
			checkValue("uOpStallD", uOpStallD, expCtl[2]);
			checkValue("prevRsrState", prevRsrState, expCtl[1]);
			checkValue("keepV", keepV, expCtl[0]);
			checkValue("expansionCount", expansionCount, mCount);
			expUopStall = expCtl[2];
			if (!stallUop) begin
				if (mState == S_READY && nextSt != S_READY)
					mCount = mCount + 1'b1; // Expansion starts on this edge
				mState = nextSt;
			end
			if (cfgWrite)
				mEnables = cfgData;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	task automatic runTest(input string name, input int mode, input int cycles);
		int         errorsBefore;
		int         kind;
		logic [3:0] cond;
		logic       holding;
		errorsBefore = errorCount;
		repeat (cycles) begin
			@(posedge clk);
			holding = expUopStall || stallUop; // Fetch keeps the word
			cfgWrite <= 1'b0;
			stallUop <= (mode == M_STALL) ? (randBits(2) == 2'b00) : 1'b0;
			if (!holding) begin
				case (mode)
					M_PASS:  kind = K_PLAIN;
					M_RSR:   kind = (randBits(2) != 2'b11) ? K_RSR : K_PLAIN;
					M_MAC:   kind = (randBits(1) == 1'b1) ? K_SHORT : K_LONG;
					default: kind = randBits(2);
				endcase
				cond = (mode == M_PASS || mode == M_COND) ? randBits(4) : 4'hE;
				defaultInstrD <= makeInstr(kind, cond);
				if (mode == M_COND) begin
					flags <= randBits(4);
					if (randBits(3) == 3'b000) begin
						cfgWrite <= 1'b1; // Enables change under the stream
						cfgData  <= randBits(2);
					end
				end
			end
		end
		$display("Test %s: %0d cycles, %0d errors", name, cycles, errorCount - errorsBefore);
	endtask

	initial begin
		lfsrState     = 16'd61;
		reset         = 1'b1;
		defaultInstrD = '0;
		stallUop      = 1'b0;
		flags         = 4'b0000;
		cfgWrite      = 1'b0;
		cfgData       = 2'b11;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		runTest("passThrough", M_PASS, N_PASS);
		runTest("rsrSequence", M_RSR, N_RSR);
		runTest("macSequence", M_MAC, N_MAC);
		runTest("condAndDisable", M_COND, N_COND);
		@(posedge clk);
		cfgWrite <= 1'b1; // Both classes back on
		cfgData  <= 2'b11;
		runTest("stallMidSequence", M_STALL, N_STALL);
		repeat (2) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: microOp_params.svh
// Micro-op expansion widths
`ifndef MICROOP_PARAMS_SVH
`define MICROOP_PARAMS_SVH

// Instruction word width, fixed by the ISA
`define INSTR_WIDTH 32

// Expansion counter width, wraps at the top
`define COUNT_WIDTH 16

// Enable bits after reset {MAC, RSR}
`define CFG_RESET 2'b11

`endif

// File: vlog.f
+incdir+.
armInstrPkg.sv
microOpPkg.sv
condCheck.sv
microOpConfig.sv
microOpFsm.sv
decodeExpander.sv
microOpTb.sv
